// ==== logic/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

  // line geometry
  localparam int WORD_BITS      = 32;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_BITS      = WORD_BITS * WORDS_PER_LINE;
  localparam int OFFSET_BITS    = 4;                        // byte offset inside a line
  localparam int WORD_SEL_BITS  = $clog2(WORDS_PER_LINE);
  localparam int BYTE_SEL_BITS  = OFFSET_BITS - WORD_SEL_BITS;  // byte within a word

  localparam int ADDR_BITS      = 32;
  localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;

  // byte address as seen by the requester
  typedef logic [ADDR_BITS-1:0]      addr_t;
  typedef logic [WORD_BITS-1:0]      word_t;
  typedef logic [LINE_BITS-1:0]      line_t;       // word 0 in the low bits
  // address of a whole line, also kept whole as the tag
  typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

  // controller states
  typedef enum logic [1:0] {
    st_idle,        // waiting for a request
    st_compare,     // tag lookup on the registered request
    st_allocate,    // refill read in flight
    st_write_back   // dirty victim on its way out
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/mem_latency_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_latency_timer #(
  parameter int MEM_LATENCY = 4
) (
  input  wire  clk,
  input  wire  reset,
  input  wire  start,
  output logic busy,
  output logic done
);

  localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

  logic [CNT_BITS-1:0] count_q;  // cycles left, zero when idle

  if (MEM_LATENCY < 1) begin : g_bad_latency
    $error("MEM_LATENCY must be at least 1");
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count_q <= '0;
    end else if (start) begin
      count_q <= CNT_BITS'(MEM_LATENCY);
    end else if (busy) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign busy = (count_q != '0);
  assign done = (count_q == CNT_BITS'(1));  // last counted cycle

endmodule

`default_nettype wire

// ==== logic/backing_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module backing_mem #(
  parameter int MEM_LATENCY = 4,
  parameter int MEM_LINES   = 64
) (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   mem_valid,
  input  wire                   mem_write,
  input  wire cache_pkg::line_addr_t mem_line_addr,
  input  wire cache_pkg::line_t mem_wline,
  output logic                  mem_ready,
  output logic                  mem_resp_valid,
  output cache_pkg::line_t      mem_rline
);

  localparam int SLOT_BITS = $clog2(MEM_LINES);

  cache_pkg::line_t     mem_q [MEM_LINES];
  logic [SLOT_BITS-1:0] slot_q;     // latched request
  logic                 write_q;
  cache_pkg::line_t     wline_q;

  logic accept;
  logic busy;
  logic done;

  assign mem_ready = !busy;         // one request in flight at most
  assign accept    = mem_valid && mem_ready;

  mem_latency_timer #(
    .MEM_LATENCY(MEM_LATENCY)
  ) mem_latency_timer_i (
    .clk   (clk),
    .reset (reset),
    .start (accept),
    .busy  (busy),
    .done  (done)
  );

  always_ff @(posedge clk) begin
    if (accept) begin
      slot_q  <= SLOT_BITS'(mem_line_addr % MEM_LINES);  // wraps over the depth
      write_q <= mem_write;
      wline_q <= mem_wline;
    end
  end

  // the access itself takes place in the done cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < MEM_LINES; i++) begin
        mem_q[i] <= '0;
      end
    end else if (done && write_q) begin
      mem_q[slot_q] <= wline_q;
    end
  end

  assign mem_resp_valid = done;
  assign mem_rline      = write_q ? wline_q : mem_q[slot_q];  // a write echoes its line

endmodule

`default_nettype wire

// ==== logic/line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_store #(
  parameter int NUM_SETS = 16
) (
  input  wire                    clk,
  input  wire                    reset,
  input  wire cache_pkg::addr_t  req_addr,
  input  wire cache_pkg::word_t  req_wdata,
  input  wire                    word_we,
  input  wire                    fill_we,
  input  wire                    meta_we,
  input  wire                    req_write,
  input  wire cache_pkg::line_t  fill_line,
  output logic                   lookup_hit,
  output logic                   victim_dirty,
  output cache_pkg::line_addr_t  victim_line_addr,
  output cache_pkg::line_t       victim_line,
  output cache_pkg::word_t       rd_word
);

  localparam int SET_BITS = $clog2(NUM_SETS);

  cache_pkg::line_t      data_q [NUM_SETS];
  cache_pkg::line_addr_t tag_q  [NUM_SETS];
  logic [NUM_SETS-1:0]   valid_q;
  logic [NUM_SETS-1:0]   dirty_q;

  cache_pkg::line_addr_t line_addr;
  logic [SET_BITS-1:0]   set_idx;
  logic [cache_pkg::WORD_SEL_BITS-1:0] word_sel;
  cache_pkg::line_t      cur_line;
  cache_pkg::line_t      merged_line;

  assign line_addr = req_addr[cache_pkg::ADDR_BITS-1:cache_pkg::OFFSET_BITS];
  assign set_idx   = line_addr[SET_BITS-1:0];  // line address modulo NUM_SETS
  assign word_sel  = req_addr[cache_pkg::OFFSET_BITS-1:cache_pkg::BYTE_SEL_BITS];
  assign cur_line  = data_q[set_idx];

  assign lookup_hit       = valid_q[set_idx] && (tag_q[set_idx] == line_addr);
  assign victim_dirty     = valid_q[set_idx] && dirty_q[set_idx];
  assign victim_line_addr = tag_q[set_idx];   // tag is the full line address
  assign victim_line      = cur_line;
  assign rd_word          = cur_line[word_sel*cache_pkg::WORD_BITS +: cache_pkg::WORD_BITS];

  // replace one word, keep the other three
  always_comb begin
    merged_line = cur_line;
    merged_line[word_sel*cache_pkg::WORD_BITS +: cache_pkg::WORD_BITS] = req_wdata;
  end

  always_ff @(posedge clk) begin
    if (fill_we) begin
      data_q[set_idx] <= fill_line;
    end else if (word_we) begin
      data_q[set_idx] <= merged_line;
    end
    if (meta_we) begin
      tag_q[set_idx] <= line_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (meta_we) begin
      valid_q[set_idx] <= 1'b1;
      dirty_q[set_idx] <= req_write;  // a read refill leaves the line clean
    end
  end

endmodule

`default_nettype wire

// ==== logic/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
  parameter int NUM_SETS = 16
) (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    in_valid,
  input  wire cache_pkg::addr_t  addr,
  input  wire                    write,
  input  wire cache_pkg::word_t  wdata,
  input  wire                    lookup_hit,
  input  wire                    victim_dirty,
  input  wire cache_pkg::line_addr_t victim_line_addr,
  input  wire cache_pkg::line_t  victim_line,
  input  wire cache_pkg::word_t  rd_word,
  input  wire                    mem_ready,
  input  wire                    mem_resp_valid,
  input  wire cache_pkg::line_t  mem_rline,
  output logic                   ready,
  output logic                   out_valid,
  output cache_pkg::word_t       rdata,
  output logic                   hit,
  output cache_pkg::addr_t       req_addr,
  output cache_pkg::word_t       req_wdata,
  output logic                   req_write,
  output logic                   word_we,
  output logic                   fill_we,
  output logic                   meta_we,
  output cache_pkg::line_t       fill_line,
  output logic                   mem_valid,
  output logic                   mem_write,
  output cache_pkg::line_addr_t  mem_line_addr,
  output cache_pkg::line_t       mem_wline
);

  cache_pkg::ctrl_state_t state_q;
  cache_pkg::ctrl_state_t state_d;

  logic                  accept;
  logic                  miss_q;      // first compare of this request missed
  logic                  compare_miss;
  cache_pkg::line_addr_t req_line_addr;

  // set index is a plain slice of the line address in the line store
  if (NUM_SETS < 2 || (NUM_SETS & (NUM_SETS - 1)) != 0) begin : g_bad_num_sets
    $error("NUM_SETS must be a power of two and at least 2");
  end

  assign ready         = (state_q == cache_pkg::st_idle);
  assign accept        = in_valid && ready;
  assign req_line_addr = req_addr[cache_pkg::ADDR_BITS-1:cache_pkg::OFFSET_BITS];
  assign compare_miss  = (state_q == cache_pkg::st_compare) && !lookup_hit;

  // request side
  assign out_valid = (state_q == cache_pkg::st_compare) && lookup_hit;
  assign hit       = out_valid && !miss_q;
  assign rdata     = req_write ? req_wdata : rd_word;  // full-word write, merged word is wdata

  // line store writes
  assign word_we   = out_valid && req_write;
  assign fill_we   = (state_q == cache_pkg::st_allocate) && mem_resp_valid;
  assign meta_we   = word_we || fill_we;  // tag goes in at refill, dirty on write hit
  assign fill_line = mem_rline;

  always_comb begin
    state_d = state_q;
    case (state_q)
      cache_pkg::st_idle: begin
        if (accept) state_d = cache_pkg::st_compare;
      end
      cache_pkg::st_compare: begin
        if (lookup_hit) begin
          state_d = cache_pkg::st_idle;
        end else if (victim_dirty) begin
          state_d = cache_pkg::st_write_back;
        end else begin
          state_d = cache_pkg::st_allocate;
        end
      end
      cache_pkg::st_write_back: begin
        if (mem_resp_valid) state_d = cache_pkg::st_allocate;
      end
      cache_pkg::st_allocate: begin
        if (mem_resp_valid) state_d = cache_pkg::st_compare;  // retry on the filled line
      end
      default: state_d = cache_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q   <= cache_pkg::st_idle;
      miss_q    <= 1'b0;
      mem_valid <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        miss_q <= 1'b0;
      end else if (compare_miss) begin
        miss_q <= 1'b1;
      end
      // held until the memory takes it
      if (compare_miss) begin
        mem_valid <= 1'b1;
      end else if ((state_q == cache_pkg::st_write_back) && mem_resp_valid) begin
        mem_valid <= 1'b1;  // refill follows the write-back
      end else if (mem_ready) begin
        mem_valid <= 1'b0;
      end
    end
  end

  // request and memory payload
  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr  <= addr;
      req_wdata <= wdata;
      req_write <= write;
    end
    if (compare_miss && victim_dirty) begin
      mem_write     <= 1'b1;
      mem_line_addr <= victim_line_addr;
      mem_wline     <= victim_line;
    end else if (compare_miss ||
                 ((state_q == cache_pkg::st_write_back) && mem_resp_valid)) begin
      mem_write     <= 1'b0;
      mem_line_addr <= req_line_addr;
    end
  end

endmodule

`default_nettype wire

// ==== logic/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
  parameter int NUM_SETS    = 16,
  parameter int MEM_LATENCY = 4,
  parameter int MEM_LINES   = 64
) (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   in_valid,
  input  wire cache_pkg::addr_t addr,
  input  wire                   write,
  input  wire cache_pkg::word_t wdata,
  output logic                  ready,
  output logic                  out_valid,
  output cache_pkg::word_t      rdata,
  output logic                  hit
);

  // controller to line store
  cache_pkg::addr_t      req_addr;
  cache_pkg::word_t      req_wdata;
  logic                  req_write;
  logic                  word_we;
  logic                  fill_we;
  logic                  meta_we;
  cache_pkg::line_t      fill_line;
  logic                  lookup_hit;
  logic                  victim_dirty;
  cache_pkg::line_addr_t victim_line_addr;
  cache_pkg::line_t      victim_line;
  cache_pkg::word_t      rd_word;

  // controller to memory
  logic                  mem_valid;
  logic                  mem_write;
  cache_pkg::line_addr_t mem_line_addr;
  cache_pkg::line_t      mem_wline;
  logic                  mem_ready;
  logic                  mem_resp_valid;
  cache_pkg::line_t      mem_rline;

  cache_ctrl #(
    .NUM_SETS(NUM_SETS)
  ) cache_ctrl_i (
    .clk, .reset, .in_valid, .addr, .write, .wdata,
    .lookup_hit, .victim_dirty, .victim_line_addr, .victim_line, .rd_word,
    .mem_ready, .mem_resp_valid, .mem_rline,
    .ready, .out_valid, .rdata, .hit,
    .req_addr, .req_wdata, .req_write, .word_we, .fill_we, .meta_we, .fill_line,
    .mem_valid, .mem_write, .mem_line_addr, .mem_wline
  );

  line_store #(
    .NUM_SETS(NUM_SETS)
  ) line_store_i (
    .clk, .reset, .req_addr, .req_wdata, .word_we, .fill_we, .meta_we, .req_write,
    .fill_line, .lookup_hit, .victim_dirty, .victim_line_addr, .victim_line, .rd_word
  );

  backing_mem #(
    .MEM_LATENCY (MEM_LATENCY),
    .MEM_LINES   (MEM_LINES)
  ) backing_mem_i (
    .clk, .reset, .mem_valid, .mem_write, .mem_line_addr, .mem_wline,
    .mem_ready, .mem_resp_valid, .mem_rline
  );

endmodule

`default_nettype wire

// ==== sim/cache_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_sva (
  input wire clk,
  input wire reset,
  input wire in_valid,
  input wire ready,
  input wire out_valid,
  input wire hit,
  input wire mem_valid,
  input wire mem_ready
);

  // one request at a time on the request side
  out_valid_pulse: assert property (@(posedge clk) disable iff (reset)
    out_valid |=> !out_valid)
    else $error("out_valid held high for more than one cycle");

  ready_drop_on_accept: assert property (@(posedge clk) disable iff (reset)
    (in_valid && ready) |=> !ready)
    else $error("ready still high in the cycle after acceptance");

  // stays low until the cycle that ends the request
  ready_held_low: assert property (@(posedge clk) disable iff (reset)
    (!ready && !out_valid) |=> !ready)
    else $error("ready rose before out_valid");

  // a memory request only goes away once the memory took it
  mem_req_held: assert property (@(posedge clk) disable iff (reset)
    $fell(mem_valid) |-> $past(mem_ready))
    else $error("memory request dropped before it was accepted");

  hit_one_cycle: assert property (@(posedge clk) disable iff (reset)
    (out_valid && hit) |-> $past(in_valid && ready))
    else $error("hit response not one cycle after acceptance");

endmodule

bind cache_ctrl cache_sva cache_sva_i (
  .clk       (clk),
  .reset     (reset),
  .in_valid  (in_valid),
  .ready     (ready),
  .out_valid (out_valid),
  .hit       (hit),
  .mem_valid (mem_valid),
  .mem_ready (mem_ready)
);

`default_nettype wire

// ==== sim/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

  localparam int NUM_SETS    = 16;
  localparam int MEM_LATENCY = 4;
  localparam int MEM_LINES   = 64;
  localparam int MODEL_WORDS = MEM_LINES * cache_pkg::WORDS_PER_LINE;
  localparam int TIMEOUT     = 100;  // cycles per wait

  logic             clk = 1'b0;
  logic             reset;
  logic             in_valid;
  cache_pkg::addr_t addr;
  logic             write;
  cache_pkg::word_t wdata;
  logic             ready;
  logic             out_valid;
  cache_pkg::word_t rdata;
  logic             hit;

  // reference model of memory contents and tags
  cache_pkg::word_t      model_mem [MODEL_WORDS];
  cache_pkg::line_addr_t model_tag [NUM_SETS];
  bit                    model_valid [NUM_SETS];

  int errors = 0;
  int checks = 0;
  int tests  = 0;

  cache_top #(
    .NUM_SETS    (NUM_SETS),
    .MEM_LATENCY (MEM_LATENCY),
    .MEM_LINES   (MEM_LINES)
  ) cache_top_i (
    .clk, .reset, .in_valid, .addr, .write, .wdata,
    .ready, .out_valid, .rdata, .hit
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // one request through the DUT and its check against the model
  task automatic access(input logic wr, input cache_pkg::addr_t a, input cache_pkg::word_t d);
    int unsigned           waited;
    int unsigned           word_idx;
    int unsigned           set_idx;
    cache_pkg::line_addr_t line_addr;
    cache_pkg::word_t      exp_data;
    logic                  exp_hit;
    logic                  accepted;
    word_idx  = (a >> 2) % MODEL_WORDS;
    line_addr = a >> cache_pkg::OFFSET_BITS;
    set_idx   = line_addr % NUM_SETS;
    exp_hit   = model_valid[set_idx] && (model_tag[set_idx] == line_addr);
    if (wr) model_mem[word_idx] = d;
    exp_data  = model_mem[word_idx];  // a write returns the merged word
    model_valid[set_idx] = 1'b1;
    model_tag[set_idx]   = line_addr;

    @(posedge clk);
    in_valid <= 1'b1;
    addr     <= a;
    write    <= wr;
    wdata    <= d;
    waited = 0;
    @(negedge clk);
    while (!ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    accepted = ready;
    @(posedge clk);  // accepting edge when ready was high
    in_valid <= 1'b0;
    if (!accepted) begin
      $display("timeout: ready stayed low for %0d cycles, request to %h never taken", TIMEOUT, a);
      errors++;
      return;
    end

    waited = 1;
    @(negedge clk);
    while (!out_valid && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!out_valid) begin
      $display("timeout: no out_valid within %0d cycles for request to %h", TIMEOUT, a);
      errors++;
      return;
    end

    checks += 2;
    assert (rdata === exp_data) else begin
      $display("** Error at %0t: %s %h returned data %h, expected %h",
               $time, wr ? "write" : "read", a, rdata, exp_data);
      errors++;
    end
    assert (hit === exp_hit) else begin
      $display("** Error at %0t: %s %h reported hit %b, expected %b",
               $time, wr ? "write" : "read", a, hit, exp_hit);
      errors++;
    end
    if (exp_hit) begin
      checks++;
      assert (waited == 1) else begin
        $display("** Error at %0t: hit on %h took %0d cycles, expected 1", $time, a, waited);
        errors++;
      end
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - errors_before);
  endtask

  initial begin
    int               start_errors;
    logic [31:0]      seed;
    cache_pkg::addr_t a;
    reset    = 1'b1;
    in_valid = 1'b0;
    addr     = '0;
    write    = 1'b0;
    wdata    = '0;
    for (int i = 0; i < MODEL_WORDS; i++) model_mem[i] = '0;
    for (int i = 0; i < NUM_SETS; i++) begin
      model_tag[i]   = '0;
      model_valid[i] = 1'b0;
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // idle after reset and cold reads of zero
    start_errors = errors;
    @(negedge clk);
    checks++;
    assert (ready === 1'b1 && out_valid === 1'b0) else begin
      $display("** Error at %0t: after reset ready=%b out_valid=%b", $time, ready, out_valid);
      errors++;
    end
    access(1'b0, 32'h0000_0000, '0);
    access(1'b0, 32'h0000_03fc, '0);
    access(1'b0, 32'h0000_01a8, '0);
    end_test("reset state", start_errors);

    // write then read of the same word with a hit on the second
    start_errors = errors;
    access(1'b1, 32'h0000_00a4, 32'hcafe_f00d);
    access(1'b0, 32'h0000_00a4, '0);
    end_test("read after write", start_errors);

    // all four words of one line
    start_errors = errors;
    for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
      access(1'b1, 32'h0000_02c0 + 4 * w, 32'h5a00_0000 + w);
    end
    for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
      access(1'b0, 32'h0000_02c0 + 4 * w, '0);
    end
    end_test("word placement", start_errors);

    // same set and other tag forces the dirty line out and back
    start_errors = errors;
    access(1'b1, 32'h0000_0048, 32'h1234_abcd);
    access(1'b0, 32'h0000_0148, '0);
    access(1'b0, 32'h0000_0048, '0);
    end_test("dirty eviction", start_errors);

    // random reads and writes over the whole memory
    start_errors = errors;
    seed = 32'd57261;
    for (int i = 0; i < 300; i++) begin
      seed = next_rand(seed);
      a    = cache_pkg::addr_t'({seed[5:0], seed[7:6], 2'b00});
      if (seed[8]) begin
        seed = next_rand(seed);
        access(1'b1, a, seed);
      end else begin
        access(1'b0, a, '0);
      end
    end
    end_test("random mix", start_errors);

    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
logic/cache_pkg.sv
logic/mem_latency_timer.sv
logic/backing_mem.sv
logic/line_store.sv
logic/cache_ctrl.sv
logic/cache_top.sv
sim/cache_sva.sv
sim/cache_tb.sv

// ==== Makefile ====
# Verilator flow for the cache testbench

VERILATOR ?= verilator
FILELIST  ?= files.f
TOP       ?= cache_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Test passed$$" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
